/* Bender.yml */
package:
  name: wdemux

sources:
  - hdl/wdemux_pkg.sv
  - hdl/id_track_if.sv
  - hdl/aw_route.sv
  - hdl/id_slot.sv
  - hdl/w_steer.sv
  - hdl/b_arbiter.sv
  - hdl/wdemux_top.sv
  - target: test
    files:
      - verification/wdemux_tb.sv

/* hdl/aw_route.sv */
// AW admission, valid lock, per-port AW valid, tracker push and W queue push
`timescale 1ns/1ps

module aw_route #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned LOOK_BITS = 2,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS)
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // slave AW
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [wdemux_pkg::ID_W-1:0] aw_id_i,
  input  logic [SEL_W-1:0]            aw_sel_i,
  // master AW valids and readies
  output logic [NUM_PORTS-1:0]        m_aw_valid_o,
  input  logic [NUM_PORTS-1:0]        m_aw_ready_i,
  // W order queue
  output logic                        q_push_o,
  output logic [SEL_W-1:0]            q_sel_o,
  input  logic                        q_full_i,
  // ID tracker
  id_track_if.router                  trk
);

  // ------------------------------
  // lookup and admission
  // ------------------------------

  logic [LOOK_BITS-1:0] look_id;
  logic                 admit;
  logic                 sel_ready;

  // slot of the incoming ID
  assign look_id = aw_id_i[LOOK_BITS-1:0];

  // no slot and no queue entry may overflow,
  // and an ID in flight may only go to the port it already uses
  assign admit = !(|trk.full) && !q_full_i &&
                 (!trk.occupied[look_id] || (trk.rec_sel[look_id] == aw_sel_i));

  // ready of the addressed master
  assign sel_ready = m_aw_ready_i[aw_sel_i];

  // ------------------------------
  // handshake control
  // ------------------------------

  logic lock_d;
  logic lock_q;
  logic aw_valid;
  logic push;

  always_comb begin
    aw_valid = 1'b0;
    push     = 1'b0;
    lock_d   = lock_q;
    if (lock_q) begin
      // route already pushed, only wait for the master
      aw_valid = 1'b1;
      if (sel_ready) begin
        lock_d = 1'b0;
      end
    end else if (aw_valid_i && admit) begin
      aw_valid = 1'b1;
      // first raise of the master valid pushes the route once
      push     = 1'b1;
      if (!sel_ready) begin
        lock_d = 1'b1;
      end
    end
  end

  // holds the master valid up until the AW is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------

  assign aw_ready_o   = aw_valid & sel_ready;
  assign m_aw_valid_o = aw_valid ? (NUM_PORTS'(1) << aw_sel_i) : '0;

  // tracker and queue see the same push
  assign trk.push     = push;
  assign trk.push_id  = look_id;
  assign trk.push_sel = aw_sel_i;
  assign q_push_o     = push;
  assign q_sel_o      = aw_sel_i;

endmodule

/* hdl/b_arbiter.sv */
// round-robin B response merge with grant lock-in and tracker pop
`timescale 1ns/1ps

module b_arbiter #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned LOOK_BITS = 2,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // master B channels
  input  logic [NUM_PORTS-1:0]                          m_b_valid_i,
  output logic [NUM_PORTS-1:0]                          m_b_ready_o,
  input  logic [NUM_PORTS-1:0][wdemux_pkg::ID_W-1:0]   m_b_id_i,
  input  logic [NUM_PORTS-1:0][wdemux_pkg::RESP_W-1:0] m_b_resp_i,
  // slave B channel
  output logic                                          b_valid_o,
  input  logic                                          b_ready_i,
  output logic [wdemux_pkg::ID_W-1:0]                  b_id_o,
  output logic [wdemux_pkg::RESP_W-1:0]                b_resp_o,
  // ID tracker
  id_track_if.drain                                     trk
);

  logic [SEL_W-1:0] prio_q;
  logic [SEL_W-1:0] rr_idx;
  logic [SEL_W-1:0] gnt_idx;
  logic [SEL_W-1:0] lock_idx_q;
  logic             lock_q;
  logic             hs;

  // ------------------------------
  // round-robin search
  // ------------------------------

  // first valid master at or after the priority pointer
  always_comb begin : rr_search
    int unsigned idx;
    logic        found;
    rr_idx = prio_q;
    found  = 1'b0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      idx = prio_q + i;
      if (idx >= NUM_PORTS) begin
        idx = idx - NUM_PORTS;
      end
      if (!found && m_b_valid_i[idx]) begin
        found  = 1'b1;
        rr_idx = SEL_W'(idx);
      end
    end
  end

  // a stalled response keeps its grant
  assign gnt_idx = lock_q ? lock_idx_q : rr_idx;

  // ------------------------------
  // mux and handshake
  // ------------------------------

  assign b_valid_o   = m_b_valid_i[gnt_idx];
  assign b_id_o      = m_b_id_i[gnt_idx];
  assign b_resp_o    = m_b_resp_i[gnt_idx];
  assign m_b_ready_o = (b_valid_o && b_ready_i) ? (NUM_PORTS'(1) << gnt_idx) : '0;
  assign hs          = b_valid_o && b_ready_i;

  // tracker slot of the response ID drops at this edge
  assign trk.pop    = hs;
  assign trk.pop_id = b_id_o[LOOK_BITS-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (b_valid_o && !b_ready_i) begin
        lock_q     <= 1'b1;
        lock_idx_q <= gnt_idx;
      end else if (hs) begin
        lock_q <= 1'b0;
        // move priority past the winner
        prio_q <= (gnt_idx == SEL_W'(NUM_PORTS - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

endmodule

/* hdl/id_slot.sv */
// one ID tracker slot: outstanding write count and recorded master port
`timescale 1ns/1ps

module id_slot #(
  parameter int unsigned SLOT      = 0,
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned LOOK_BITS = 2,
  parameter int unsigned MAX_TRANS = 4,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS),
  localparam int unsigned CNT_W    = $clog2(MAX_TRANS + 1)
) (
  input logic      clk_i,
  input logic      rst_i,
  id_track_if.slot trk
);

  logic             push_hit;
  logic             pop_hit;
  logic [CNT_W-1:0] cnt_q;
  logic [SEL_W-1:0] sel_q;

  // events addressed to this slot
  assign push_hit = trk.push && (trk.push_id == LOOK_BITS'(SLOT));
  assign pop_hit  = trk.pop && (trk.pop_id == LOOK_BITS'(SLOT));

  // outstanding count, push and pop together leave it as is
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (push_hit && !pop_hit) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (pop_hit && !push_hit) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // port of the writes in flight
  // only read while the count is above zero
  always_ff @(posedge clk_i) begin
    if (push_hit) begin
      sel_q <= trk.push_sel;
    end
  end

  assign trk.occupied[SLOT] = (cnt_q != '0);
  assign trk.full[SLOT]     = (cnt_q == CNT_W'(MAX_TRANS));
  assign trk.rec_sel[SLOT]  = sel_q;

endmodule

/* hdl/id_track_if.sv */
// interface between the AW router, the ID tracker slots and the B arbiter
`timescale 1ns/1ps

interface id_track_if #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned LOOK_BITS = 2,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS),
  localparam int unsigned SLOTS    = 2 ** LOOK_BITS
);

  // push side, one new write per cycle at most
  logic                 push;
  logic [LOOK_BITS-1:0] push_id;
  logic [SEL_W-1:0]     push_sel;

  // pop side, one B handed over per cycle at most
  logic                 pop;
  logic [LOOK_BITS-1:0] pop_id;

  // per-slot status, entry k comes from slot k
  logic [SLOTS-1:0]            occupied;
  logic [SLOTS-1:0]            full;
  logic [SLOTS-1:0][SEL_W-1:0] rec_sel;

  // AW side: pushes and looks up the slot state
  modport router (output push, push_id, push_sel, input occupied, full, rec_sel);

  // one tracker slot
  modport slot (input push, push_id, push_sel, pop, pop_id, output occupied, full, rec_sel);

  // B side: pops on each response handshake
  modport drain (output pop, pop_id);

endinterface

/* hdl/w_steer.sv */
// W order queue and steering of W beats to the port of the oldest open AW
`timescale 1ns/1ps

module w_steer #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned MAX_TRANS = 4,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS),
  localparam int unsigned PTR_W    = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1,
  localparam int unsigned CNT_W    = $clog2(MAX_TRANS + 1)
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // route pushes from the AW side
  input  logic                 q_push_i,
  input  logic [SEL_W-1:0]     q_sel_i,
  output logic                 q_full_o,
  // slave W handshake
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  logic                 w_last_i,
  // master W valids and readies
  output logic [NUM_PORTS-1:0] m_w_valid_o,
  input  logic [NUM_PORTS-1:0] m_w_ready_i
);

  // ------------------------------
  // order queue
  // ------------------------------

  logic [SEL_W-1:0] mem [MAX_TRANS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             empty;
  logic             pop;
  logic [SEL_W-1:0] head;

  assign empty    = (cnt_q == '0);
  assign q_full_o = (cnt_q == CNT_W'(MAX_TRANS));

  // head comes from storage only, so a fresh entry shows one cycle later
  assign head = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (q_push_i) begin
      mem[wr_ptr_q] <= q_sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (q_push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // occupancy
      case ({q_push_i, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ------------------------------
  // beat steering
  // ------------------------------

  // nothing passes while no route is queued
  assign w_ready_o   = !empty && m_w_ready_i[head];
  assign m_w_valid_o = (!empty && w_valid_i) ? (NUM_PORTS'(1) << head) : '0;

  // burst ends on the last beat handshake
  assign pop = w_valid_i && w_ready_o && w_last_i;

endmodule

/* hdl/wdemux_pkg.sv */
// default widths and sizes of the write-path demultiplexer
package wdemux_pkg;

  // ------------------------------
  // structure
  // ------------------------------

  // number of master ports behind the demux
  parameter int unsigned NUM_PORTS = 4;

  // low ID bits that index the tracker, 2**LOOK_BITS slots
  parameter int unsigned LOOK_BITS = 2;

  // outstanding writes per slot, also the W order queue depth
  parameter int unsigned MAX_TRANS = 4;

  // ------------------------------
  // field widths
  // ------------------------------

  // transaction ID
  parameter int unsigned ID_W = 4;

  // write address
  parameter int unsigned ADDR_W = 16;

  // write data beat
  parameter int unsigned DATA_W = 32;

  // B response code
  parameter int unsigned RESP_W = 2;

endpackage

/* hdl/wdemux_top.sv */
// top level of the write-path demux: AW router, ID tracker, W steering, B merge
`timescale 1ns/1ps

module wdemux_top #(
  parameter int unsigned NUM_PORTS = wdemux_pkg::NUM_PORTS,
  parameter int unsigned LOOK_BITS = wdemux_pkg::LOOK_BITS,
  parameter int unsigned MAX_TRANS = wdemux_pkg::MAX_TRANS,
  localparam int unsigned SEL_W    = $clog2(NUM_PORTS)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // slave AW
  input  logic                                          aw_valid_i,
  output logic                                          aw_ready_o,
  input  logic [wdemux_pkg::ID_W-1:0]                  aw_id_i,
  input  logic [wdemux_pkg::ADDR_W-1:0]                aw_addr_i,
  input  logic [SEL_W-1:0]                              aw_sel_i,
  // slave W
  input  logic                                          w_valid_i,
  output logic                                          w_ready_o,
  input  logic [wdemux_pkg::DATA_W-1:0]                w_data_i,
  input  logic                                          w_last_i,
  // slave B
  output logic                                          b_valid_o,
  input  logic                                          b_ready_i,
  output logic [wdemux_pkg::ID_W-1:0]                  b_id_o,
  output logic [wdemux_pkg::RESP_W-1:0]                b_resp_o,
  // master AW
  output logic [NUM_PORTS-1:0]                          m_aw_valid_o,
  input  logic [NUM_PORTS-1:0]                          m_aw_ready_i,
  output logic [wdemux_pkg::ID_W-1:0]                  m_aw_id_o,
  output logic [wdemux_pkg::ADDR_W-1:0]                m_aw_addr_o,
  // master W
  output logic [NUM_PORTS-1:0]                          m_w_valid_o,
  input  logic [NUM_PORTS-1:0]                          m_w_ready_i,
  output logic [wdemux_pkg::DATA_W-1:0]                m_w_data_o,
  output logic                                          m_w_last_o,
  // master B
  input  logic [NUM_PORTS-1:0]                          m_b_valid_i,
  output logic [NUM_PORTS-1:0]                          m_b_ready_o,
  input  logic [NUM_PORTS-1:0][wdemux_pkg::ID_W-1:0]   m_b_id_i,
  input  logic [NUM_PORTS-1:0][wdemux_pkg::RESP_W-1:0] m_b_resp_i
);

  // route handoff to the W queue
  logic             q_push;
  logic [SEL_W-1:0] q_sel;
  logic             q_full;

  // payload fields go to every port, only valids are per port
  assign m_aw_id_o   = aw_id_i;
  assign m_aw_addr_o = aw_addr_i;
  assign m_w_data_o  = w_data_i;
  assign m_w_last_o  = w_last_i;

  id_track_if #(.NUM_PORTS(NUM_PORTS), .LOOK_BITS(LOOK_BITS)) trk_if ();

  aw_route #(.NUM_PORTS(NUM_PORTS), .LOOK_BITS(LOOK_BITS)) u_aw_route (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .aw_valid_i   (aw_valid_i),
    .aw_ready_o   (aw_ready_o),
    .aw_id_i      (aw_id_i),
    .aw_sel_i     (aw_sel_i),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .q_push_o     (q_push),
    .q_sel_o      (q_sel),
    .q_full_i     (q_full),
    .trk          (trk_if.router)
  );

  // one tracker slot per value of the low ID bits
  for (genvar k = 0; k < 2 ** LOOK_BITS; k++) begin : gen_slot
    id_slot #(
      .SLOT      (k),
      .NUM_PORTS (NUM_PORTS),
      .LOOK_BITS (LOOK_BITS),
      .MAX_TRANS (MAX_TRANS)
    ) u_id_slot (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .trk   (trk_if.slot)
    );
  end

  w_steer #(.NUM_PORTS(NUM_PORTS), .MAX_TRANS(MAX_TRANS)) u_w_steer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .q_push_i    (q_push),
    .q_sel_i     (q_sel),
    .q_full_o    (q_full),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_last_i    (w_last_i),
    .m_w_valid_o (m_w_valid_o),
    .m_w_ready_i (m_w_ready_i)
  );

  b_arbiter #(.NUM_PORTS(NUM_PORTS), .LOOK_BITS(LOOK_BITS)) u_b_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .m_b_valid_i (m_b_valid_i),
    .m_b_ready_o (m_b_ready_o),
    .m_b_id_i    (m_b_id_i),
    .m_b_resp_i  (m_b_resp_i),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .b_id_o      (b_id_o),
    .b_resp_o    (b_resp_o),
    .trk         (trk_if.drain)
  );

endmodule

/* src.f */
hdl/wdemux_pkg.sv
hdl/id_track_if.sv
hdl/aw_route.sv
hdl/id_slot.sv
hdl/w_steer.sv
hdl/b_arbiter.sv
hdl/wdemux_top.sv
verification/wdemux_tb.sv

/* verification/wdemux_tb.sv */
// testbench of the write demux: clock, reset, master models, AW and W drivers, scoreboard, reporting
`timescale 1ns/1ps

module wdemux_tb;

  import wdemux_pkg::*;

  localparam int SEL_W       = $clog2(NUM_PORTS);
  localparam int SLOTS       = 2 ** LOOK_BITS;
  localparam int MAX_LEN     = 4;
  localparam int N_ROUTE     = 24;
  localparam int N_MERGE     = 32;
  // directed tests add 5 beats for ordering and MAX_TRANS + 1 for capacity
  localparam int TOTAL_BEATS = (N_ROUTE + N_MERGE) * MAX_LEN + 5 + MAX_TRANS + 1;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

  logic                              clk_i;
  logic                              rst_i;
  logic                              aw_valid_i;
  logic                              aw_ready_o;
  logic [ID_W-1:0]                   aw_id_i;
  logic [ADDR_W-1:0]                 aw_addr_i;
  logic [SEL_W-1:0]                  aw_sel_i;
  logic                              w_valid_i;
  logic                              w_ready_o;
  logic [DATA_W-1:0]                 w_data_i;
  logic                              w_last_i;
  logic                              b_valid_o;
  logic                              b_ready_i;
  logic [ID_W-1:0]                   b_id_o;
  logic [RESP_W-1:0]                 b_resp_o;
  logic [NUM_PORTS-1:0]              m_aw_valid_o;
  logic [NUM_PORTS-1:0]              m_aw_ready_i;
  logic [ID_W-1:0]                   m_aw_id_o;
  logic [ADDR_W-1:0]                 m_aw_addr_o;
  logic [NUM_PORTS-1:0]              m_w_valid_o;
  logic [NUM_PORTS-1:0]              m_w_ready_i;
  logic [DATA_W-1:0]                 m_w_data_o;
  logic                              m_w_last_o;
  logic [NUM_PORTS-1:0]              m_b_valid_i;
  logic [NUM_PORTS-1:0]              m_b_ready_o;
  logic [NUM_PORTS-1:0][ID_W-1:0]    m_b_id_i;
  logic [NUM_PORTS-1:0][RESP_W-1:0]  m_b_resp_i;

  // burst length travels beside the AW, seen by the TB only
  int aw_len_r;

  // run state
  int errors;
  int cycles;
  int aw_sent;
  int b_recv;
  int b_issued;
  int b_credit;

  // scoreboard: expected W order and ID tracker model
  int wsb_sel_q [$];
  int wsb_len_q [$];
  int wsb_tag_q [$];
  int wsb_beat;
  int trk_cnt [SLOTS];
  int trk_port [SLOTS];
  int exp_beats [NUM_PORTS];
  int sent_per_id [2 ** ID_W];
  int recv_per_id [2 ** ID_W];

  // master models
  int port_ids [NUM_PORTS][$];
  int bursts_done [NUM_PORTS];
  int beats_got [NUM_PORTS];
  int b_wait [NUM_PORTS];

  // W driver
  int bl_q [$];
  int tag_q [$];
  int w_beat;
  int aw_tag;

  wdemux_top #(
    .NUM_PORTS (NUM_PORTS),
    .LOOK_BITS (LOOK_BITS),
    .MAX_TRANS (MAX_TRANS)
  ) uut (.*);

  // ------------------------------
  // reporting helpers
  // ------------------------------

  function automatic void report_value(input string sig, input longint got, input longint exp);
    errors++;
    $display("error %0t %s: got %0h, expected %0h", $time, sig, got, exp);
  endfunction

  function automatic void report_text(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endfunction

  task automatic finish_test(input int num, input string name, input int err_mark);
    $display("test %0d %-12s %s, %0d errors", num, name,
             (errors == err_mark) ? "ok" : "mismatch", errors - err_mark);
  endtask

  // stall expected from the ordering and capacity rules
  function automatic bit aw_blocked(input int look, input int sel);
    bit blocked;
    blocked = (trk_cnt[look] > 0) && (trk_port[look] != sel);
    for (int k = 0; k < SLOTS; k++) begin
      if (trk_cnt[k] == MAX_TRANS) begin
        blocked = 1'b1;
      end
    end
    return blocked;
  endfunction

  // ------------------------------
  // clock, timeout, slave B ready
  // ------------------------------

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // random back-pressure on the slave B channel
  always @(posedge clk_i) begin
    b_ready_i <= rst_i ? 1'b0 : (($urandom % 3) != 0);
  end

  // ------------------------------
  // master models
  // ------------------------------

  always @(posedge clk_i) begin : masters
    if (rst_i) begin
      m_aw_ready_i <= '0;
      m_w_ready_i  <= '0;
      m_b_valid_i  <= '0;
      m_b_id_i     <= '0;
      m_b_resp_i   <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        m_aw_ready_i[p] <= ($urandom % 2) == 0;
        m_w_ready_i[p]  <= ($urandom % 4) != 0;
        if (m_aw_valid_o[p] && m_aw_ready_i[p]) begin
          port_ids[p].push_back(int'(m_aw_id_o));
        end
        if (m_w_valid_o[p] && m_w_ready_i[p]) begin
          beats_got[p]++;
          if (m_w_last_o) begin
            bursts_done[p]++;
          end
        end
        // one B per write with both AW and last beat seen, after a random delay
        if (!m_b_valid_i[p] || m_b_ready_o[p]) begin
          m_b_valid_i[p] <= 1'b0;
          if (bursts_done[p] > 0 && port_ids[p].size() > 0 && b_credit > 0) begin
            if (b_wait[p] > 0) begin
              b_wait[p]--;
            end else begin
              m_b_valid_i[p] <= 1'b1;
              m_b_id_i[p]    <= ID_W'(port_ids[p].pop_front());
              m_b_resp_i[p]  <= RESP_W'(p);
              bursts_done[p]--;
              b_credit--;
              b_issued++;
              b_wait[p] = $urandom % 4;
            end
          end
        end
      end
    end
  end

  // ------------------------------
  // slave W driver
  // ------------------------------

  // bursts are sent in AW acceptance order
  always @(posedge clk_i) begin : w_driver
    if (rst_i) begin
      w_valid_i <= 1'b0;
      w_data_i  <= '0;
      w_last_i  <= 1'b0;
      w_beat = 0;
    end else begin
      if (aw_valid_i && aw_ready_o) begin
        bl_q.push_back(aw_len_r);
        tag_q.push_back(aw_tag);
        aw_tag++;
      end
      if (w_valid_i && w_ready_o) begin
        if (w_last_i) begin
          void'(bl_q.pop_front());
          void'(tag_q.pop_front());
          w_beat = 0;
        end else begin
          w_beat++;
        end
      end
      if (bl_q.size() > 0) begin
        w_valid_i <= 1'b1;
        w_data_i  <= DATA_W'((tag_q[0] << 16) | w_beat);
        w_last_i  <= (w_beat == bl_q[0] - 1);
      end else begin
        w_valid_i <= 1'b0;
        w_last_i  <= 1'b0;
      end
    end
  end

  // ------------------------------
  // scoreboard
  // ------------------------------

  always @(posedge clk_i) begin : scoreboard
    int look;
    int gnt;
    logic [DATA_W-1:0] exp_data;
    if (rst_i) begin
      for (int k = 0; k < SLOTS; k++) begin
        trk_cnt[k] = 0;
      end
      wsb_beat = 0;
    end else begin
      look = int'(aw_id_i[LOOK_BITS-1:0]);
      // master AW only on the selected port, fields passed through
      if (m_aw_valid_o != '0) begin
        a_route: assert (aw_valid_i && m_aw_valid_o == (NUM_PORTS'(1) << aw_sel_i))
          else report_value("m_aw_valid_o", m_aw_valid_o, NUM_PORTS'(1) << aw_sel_i);
        a_addr: assert (m_aw_addr_o == aw_addr_i)
          else report_value("m_aw_addr_o", m_aw_addr_o, aw_addr_i);
        a_id: assert (m_aw_id_o == aw_id_i)
          else report_value("m_aw_id_o", m_aw_id_o, aw_id_i);
      end
      // ordering and capacity stall
      if (aw_valid_i && aw_blocked(look, aw_sel_i)) begin
        a_stall: assert (m_aw_valid_o == '0 && !aw_ready_o)
          else report_value("m_aw_valid_o", m_aw_valid_o, 0);
      end
      // W beats go to the oldest open burst
      if (m_w_valid_o != '0) begin
        if (wsb_sel_q.size() == 0) begin
          report_text("a W beat reached a master with no AW open");
        end else begin
          exp_data = DATA_W'((wsb_tag_q[0] << 16) | wsb_beat);
          a_wport: assert (m_w_valid_o == (NUM_PORTS'(1) << wsb_sel_q[0]))
            else report_value("m_w_valid_o", m_w_valid_o, NUM_PORTS'(1) << wsb_sel_q[0]);
          a_wdata: assert (m_w_data_o == exp_data)
            else report_value("m_w_data_o", m_w_data_o, exp_data);
          a_wlast: assert (m_w_last_o == (wsb_beat == wsb_len_q[0] - 1))
            else report_value("m_w_last_o", m_w_last_o, wsb_beat == wsb_len_q[0] - 1);
        end
      end
      if (w_valid_i && w_ready_o && wsb_sel_q.size() > 0) begin
        if (w_last_i) begin
          void'(wsb_sel_q.pop_front());
          void'(wsb_len_q.pop_front());
          void'(wsb_tag_q.pop_front());
          wsb_beat = 0;
        end else begin
          wsb_beat++;
        end
      end
      // B merge: one master per handshake, its own ID and response
      gnt = -1;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (m_b_ready_o[p]) begin
          gnt = p;
        end
      end
      if (b_valid_o && b_ready_i) begin
        a_bone: assert ($countones(m_b_ready_o) == 1)
          else report_value("m_b_ready_o", m_b_ready_o, 1);
        if (gnt >= 0) begin
          a_bid: assert (b_id_o == m_b_id_i[gnt])
            else report_value("b_id_o", b_id_o, m_b_id_i[gnt]);
          a_bresp: assert (b_resp_o == RESP_W'(gnt))
            else report_value("b_resp_o", b_resp_o, gnt);
        end
        a_bflight: assert (trk_cnt[b_id_o[LOOK_BITS-1:0]] > 0)
          else report_text("a response arrived for an ID with no write in flight");
        trk_cnt[b_id_o[LOOK_BITS-1:0]]--;
        recv_per_id[b_id_o]++;
        b_recv++;
      end else begin
        a_bidle: assert (m_b_ready_o == '0)
          else report_value("m_b_ready_o", m_b_ready_o, 0);
      end
      // accepted AW enters the model
      if (aw_valid_i && aw_ready_o) begin
        trk_cnt[look]++;
        trk_port[look] = aw_sel_i;
        wsb_sel_q.push_back(aw_sel_i);
        wsb_len_q.push_back(aw_len_r);
        wsb_tag_q.push_back(aw_sent);
        exp_beats[aw_sel_i] += aw_len_r;
        sent_per_id[aw_id_i]++;
        aw_sent++;
      end
    end
  end

  // a raised valid holds with stable payload until taken
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_hold
    aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        m_aw_valid_o[p] && !m_aw_ready_i[p]
        |=> m_aw_valid_o[p] && $stable(m_aw_addr_o) && $stable(m_aw_id_o))
      else report_text($sformatf("m_aw_valid_o[%0d] dropped or changed while stalled", p));
    w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        m_w_valid_o[p] && !m_w_ready_i[p]
        |=> m_w_valid_o[p] && $stable(m_w_data_o) && $stable(m_w_last_o))
      else report_text($sformatf("m_w_valid_o[%0d] dropped or changed while stalled", p));
  end

  b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o) && $stable(b_resp_o))
    else report_text("b_valid_o dropped or b_id_o/b_resp_o changed while stalled");

  // ------------------------------
  // stimulus
  // ------------------------------

  // one AW held until aw_ready_o, optionally checked for an immediate master valid
  task automatic send_aw(input int id, input int sel, input int len, input bit expect_now);
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_id_i    <= ID_W'(id);
    aw_sel_i   <= SEL_W'(sel);
    aw_addr_i  <= ADDR_W'($urandom);
    aw_len_r   <= len;
    @(posedge clk_i);
    if (expect_now) begin
      a_now: assert (m_aw_valid_o == (NUM_PORTS'(1) << sel))
        else report_value("m_aw_valid_o", m_aw_valid_o, NUM_PORTS'(1) << sel);
    end
    while (!aw_ready_o) begin
      @(posedge clk_i);
    end
    aw_valid_i <= 1'b0;
  endtask

  task automatic random_writes(input int n);
    for (int i = 0; i < n; i++) begin
      send_aw($urandom % (2 ** ID_W), $urandom % NUM_PORTS, 1 + $urandom % MAX_LEN, 1'b0);
    end
  endtask

  // all bursts ended and every response handed over
  task automatic wait_idle();
    @(negedge clk_i);
    while (wsb_sel_q.size() != 0 || b_recv != aw_sent) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
  endtask

  initial begin : main
    int err_mark;
    int recv_mark;
    int beats;
    void'($urandom(32'hf7a5));
    rst_i        = 1'b1;
    aw_valid_i   = 1'b0;
    aw_id_i      = '0;
    aw_addr_i    = '0;
    aw_sel_i     = '0;
    aw_len_r     = 1;
    w_valid_i    = 1'b0;
    w_data_i     = '0;
    w_last_i     = 1'b0;
    b_ready_i    = 1'b0;
    m_aw_ready_i = '0;
    m_w_ready_i  = '0;
    m_b_valid_i  = '0;
    m_b_id_i     = '0;
    m_b_resp_i   = '0;
    b_credit     = 1_000_000;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // 1: idle outputs after reset
    err_mark = errors;
    repeat (3) begin
      @(negedge clk_i);
      a_idle: assert (m_aw_valid_o == '0 && m_w_valid_o == '0 && !b_valid_o &&
                      !w_ready_o && !aw_ready_o)
        else report_text("an output was active after reset with no stimulus");
    end
    finish_test(1, "reset", err_mark);

    // 2: random traffic, routing checked by the scoreboard
    err_mark = errors;
    random_writes(N_ROUTE);
    wait_idle();
    finish_test(2, "aw routing", err_mark);

    // 3: beat count per port
    err_mark = errors;
    for (int p = 0; p < NUM_PORTS; p++) begin
      a_beats: assert (beats_got[p] == exp_beats[p])
        else report_value($sformatf("W beats on port %0d", p), beats_got[p], exp_beats[p]);
    end
    finish_test(3, "w steering", err_mark);

    // 4: same slot, second port waits for the responses of the first
    err_mark = errors;
    @(negedge clk_i) b_credit = 0;
    send_aw(1, 0, 2, 1'b1);
    send_aw(9, 0, 2, 1'b1);
    fork
      send_aw(5, 1, 1, 1'b0);
      begin
        repeat (12) @(negedge clk_i);
        a_order: assert (!aw_ready_o && m_aw_valid_o == '0)
          else report_text("an AW to a second port was not stalled behind its ID");
        b_credit = 1_000_000;
      end
    join
    wait_idle();
    finish_test(4, "ordering", err_mark);

    // 5: a full slot stalls until one response is handed over
    err_mark = errors;
    @(negedge clk_i) b_credit = 0;
    for (int i = 0; i < MAX_TRANS; i++) begin
      send_aw(2, 2, 1, 1'b0);
    end
    fork
      send_aw(2, 2, 1, 1'b0);
      begin
        repeat (12) @(negedge clk_i);
        a_full: assert (!aw_ready_o && m_aw_valid_o == '0)
          else report_text("a write beyond the tracker capacity was accepted");
        recv_mark = b_recv;
        b_credit  = 1;
      end
    join
    a_single: assert (b_recv == recv_mark + 1)
      else report_value("responses before admission", b_recv - recv_mark, 1);
    @(negedge clk_i) b_credit = 1_000_000;
    wait_idle();
    finish_test(5, "capacity", err_mark);

    // 6: B merge under random back-pressure
    err_mark = errors;
    random_writes(N_MERGE);
    wait_idle();
    for (int id = 0; id < 2 ** ID_W; id++) begin
      a_per_id: assert (recv_per_id[id] == sent_per_id[id])
        else report_value($sformatf("responses for ID %0d", id), recv_per_id[id], sent_per_id[id]);
    end
    a_count: assert (b_issued == b_recv)
      else report_value("responses received", b_recv, b_issued);
    finish_test(6, "b merge", err_mark);

    beats = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      beats += beats_got[p];
    end
    $display("tests 6, writes %0d, beats %0d, responses %0d, errors %0d",
             aw_sent, beats, b_recv, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
